// File: design/blimp_pkg.sv
// Blimp core shared definitions
// Widths, ALU operation codes, RV32I opcodes and the stage payload structs
`default_nettype none

package blimp_pkg;

  // --------------------
  // Widths
  // --------------------

  localparam int xlen          = 32;
  localparam int reg_addr_bits = 5;
  localparam int num_regs      = 32;

  // addi x0, x0, 0
  localparam logic [xlen-1:0] nop_inst = 32'h0000_0013;

  // --------------------
  // RV32I encodings
  // --------------------

  // Major opcodes, bits [6:0]
  localparam logic [6:0] opc_op     = 7'b011_0011;
  localparam logic [6:0] opc_op_imm = 7'b001_0011;
  localparam logic [6:0] opc_lui    = 7'b011_0111;

  // funct3 for the supported ops
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct7, only SUB sets bit 5
  localparam logic [6:0] f7_base = 7'b000_0000;
  localparam logic [6:0] f7_alt  = 7'b010_0000;

  // --------------------
  // ALU ops and payloads
  // --------------------

  // pass_b also covers LUI and retired no-ops
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_t;

  // Fetch to decode
  typedef struct packed {
    logic [xlen-1:0] inst;
  } inst_msg_t;

  // Decode to execute, operands already resolved
  typedef struct packed {
    alu_op_t                  alu_op;
    logic [xlen-1:0]          op_a;
    logic [xlen-1:0]          op_b;
    logic [reg_addr_bits-1:0] waddr;
    logic                     wen;
  } dec_msg_t;

  // Execute to result
  typedef struct packed {
    logic [reg_addr_bits-1:0] waddr;
    logic [xlen-1:0]          wdata;
    logic                     wen;
  } res_msg_t;

endpackage

`default_nettype wire

// File: design/blimp_pipe_if.sv
// Blimp stage-to-stage pipe
// val/rdy handshake with the pc carried beside a typed payload
`timescale 1ns/1ps
`default_nettype none

interface blimp_pipe_if #(
  parameter type t_msg = logic
);
  import blimp_pkg::*;

  // Transfer when val and rdy are both high
  logic            val;
  logic            rdy;
  // Instruction address, travels with every message
  logic [xlen-1:0] pc;
  t_msg            msg;

  // Producer side
  modport up (
    output val,
    output pc,
    output msg,
    input  rdy
  );

  // Consumer side
  modport down (
    input  val,
    input  pc,
    input  msg,
    output rdy
  );

endinterface

`default_nettype wire

// File: design/blimp_fetch.sv
// Blimp fetch stage
// Holds the pc and reads instructions as an AXI4-Lite read master,
// one read outstanding, into a registered f2d output
`timescale 1ns/1ps
`default_nettype none

module blimp_fetch (
  input  logic                       clk,
  input  logic                       rst_n,
  output logic [blimp_pkg::xlen-1:0] araddr,
  output logic                       arvalid,
  input  logic                       arready,
  input  logic [blimp_pkg::xlen-1:0] rdata,
  input  logic                       rvalid,
  output logic                       rready,
  blimp_pipe_if.up                   f2d
);
  import blimp_pkg::*;

  // Address phase, wait for data, hold until decode drains
  typedef enum logic [1:0] {st_addr, st_wait, st_hold} state_t;

  state_t          state;
  logic [xlen-1:0] pc;
  logic            out_val;
  logic [xlen-1:0] out_pc;
  inst_msg_t       out_msg;
  logic            ar_fire;
  logic            r_fire;
  logic            f2d_fire;

  assign ar_fire  = arvalid && arready;
  assign r_fire   = rvalid && rready;
  assign f2d_fire = out_val && f2d.rdy;

  // AR channel straight from state and pc
  assign arvalid = (state == st_addr);
  assign araddr  = pc;
  // Only take data into an empty output register
  assign rready  = (state == st_wait) && !out_val;

  // --------------------
  // Request FSM
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Starts in hold so arvalid rises one cycle after reset
      state <= st_hold;
      pc    <= '0;
    end else begin
      case (state)
        st_addr: begin
          if (ar_fire) state <= st_wait;
        end
        st_wait: begin
          if (r_fire) begin
            // No branches so always the next word
            pc    <= pc + xlen'(4);
            // If decode is stalled wait for the f2d transfer first
            state <= f2d.rdy ? st_addr : st_hold;
          end
        end
        st_hold: begin
          if (!out_val || f2d_fire) state <= st_addr;
        end
        default: state <= st_hold;
      endcase
    end
  end

  // --------------------
  // f2d output register
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_val <= 1'b0;
    end else if (r_fire) begin
      out_val <= 1'b1;
    end else if (f2d_fire) begin
      out_val <= 1'b0;
    end
  end

  // Payload loads with the data beat
  always_ff @(posedge clk) begin
    if (r_fire) begin
      out_pc       <= pc;
      out_msg.inst <= rdata;
    end
  end

  assign f2d.val = out_val;
  assign f2d.pc  = out_pc;
  assign f2d.msg = out_msg;

  // AXI address held until the slave takes it
  assert property (@(posedge clk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("arvalid dropped or araddr changed before arready");

endmodule

`default_nettype wire

// File: design/blimp_decode.sv
// Blimp decode stage
// Decodes the supported RV32I subset, reads the register file and stalls
// on pending destinations tracked by a scoreboard
`timescale 1ns/1ps
`default_nettype none

module blimp_decode (
  input  logic                                 clk,
  input  logic                                 rst_n,
  blimp_pipe_if.down                           f2d,
  blimp_pipe_if.up                             d2x,
  input  logic                                 rf_wen,
  input  logic [blimp_pkg::reg_addr_bits-1:0]  rf_waddr,
  input  logic [blimp_pkg::xlen-1:0]           rf_wdata
);
  import blimp_pkg::*;

  logic [xlen-1:0]          regs [num_regs];
  logic [num_regs-1:0]      sb;
  logic [num_regs-1:0]      sb_clr;
  logic [num_regs-1:0]      out_pend;
  logic [num_regs-1:0]      pending;
  logic [xlen-1:0]          inst;
  logic [reg_addr_bits-1:0] rs1;
  logic [reg_addr_bits-1:0] rs2;
  logic [reg_addr_bits-1:0] rd;
  logic [xlen-1:0]          rs1_val;
  logic [xlen-1:0]          rs2_val;
  alu_op_t                  dec_op;
  logic [xlen-1:0]          dec_b;
  logic                     dec_wen;
  logic                     known;
  logic                     use_rs1;
  logic                     use_rs2;
  logic                     stall;
  logic                     out_val;
  logic [xlen-1:0]          out_pc;
  dec_msg_t                 out_msg;
  logic                     f2d_fire;
  logic                     d2x_fire;

  // Idle input decodes as a nop, so no stale stall
  assign inst = f2d.val ? f2d.msg.inst : nop_inst;
  assign rs1  = inst[19:15];
  assign rs2  = inst[24:20];
  assign rd   = inst[11:7];

  // --------------------
  // Register file
  // --------------------

  always_ff @(posedge clk) begin
    if (rf_wen && rf_waddr != '0) regs[rf_waddr] <= rf_wdata;
  end

  // x0 reads zero, same-cycle writes bypass the array
  assign rs1_val = (rs1 == '0) ? '0 :
                   (rf_wen && rf_waddr == rs1) ? rf_wdata : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 :
                   (rf_wen && rf_waddr == rs2) ? rf_wdata : regs[rs2];

  // --------------------
  // Instruction decode
  // --------------------

  always_comb begin
    dec_op  = alu_pass_b;
    dec_b   = '0;
    known   = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (inst[6:0])
      opc_op: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        dec_b   = rs2_val;
        known   = (inst[31:25] == f7_base);
        case (inst[14:12])
          f3_add_sub: begin
            dec_op = inst[30] ? alu_sub : alu_add;
            known  = (inst[31:25] == f7_base) || (inst[31:25] == f7_alt);
          end
          f3_slt:  dec_op = alu_slt;
          f3_xor:  dec_op = alu_xor;
          f3_or:   dec_op = alu_or;
          f3_and:  dec_op = alu_and;
          default: known  = 1'b0;
        endcase
      end
      opc_op_imm: begin
        // ADDI only, sign-extended 12-bit immediate
        if (inst[14:12] == f3_add_sub) begin
          dec_op  = alu_add;
          dec_b   = {{20{inst[31]}}, inst[31:20]};
          use_rs1 = 1'b1;
          known   = 1'b1;
        end
      end
      opc_lui: begin
        dec_b = {inst[31:12], 12'b0};
        known = 1'b1;
      end
      default: known = 1'b0;
    endcase
    // Unknown words retire as no-ops and wait on nothing
    if (!known) begin
      dec_op  = alu_pass_b;
      dec_b   = '0;
      use_rs1 = 1'b0;
      use_rs2 = 1'b0;
    end
  end

  assign dec_wen = known && (rd != '0);

  // --------------------
  // Scoreboard and stall
  // --------------------

  always_comb begin
    sb_clr   = '0;
    out_pend = '0;
    if (rf_wen) sb_clr[rf_waddr] = 1'b1;
    // Held output counts as pending before its bit is set
    if (out_val && out_msg.wen) out_pend[out_msg.waddr] = 1'b1;
  end

  assign pending = (sb & ~sb_clr) | out_pend;

  // RAW on sources, WAW on the destination
  assign stall = (use_rs1 && pending[rs1]) ||
                 (use_rs2 && pending[rs2]) ||
                 (dec_wen && pending[rd]);

  assign f2d.rdy  = !stall && (!out_val || d2x.rdy);
  assign f2d_fire = f2d.val && f2d.rdy;
  assign d2x_fire = out_val && d2x.rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sb      <= '0;
      out_val <= 1'b0;
    end else begin
      // Set wins over a clear on the same register
      sb <= (sb & ~sb_clr) | (d2x_fire ? out_pend : '0);
      if (f2d_fire) out_val <= 1'b1;
      else if (d2x_fire) out_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (f2d_fire) begin
      out_pc  <= f2d.pc;
      out_msg <= '{alu_op: dec_op, op_a: rs1_val, op_b: dec_b, waddr: rd, wen: dec_wen};
    end
  end

  assign d2x.val = out_val;
  assign d2x.pc  = out_pc;
  assign d2x.msg = out_msg;

  // Held message must not move under back-pressure
  assert property (@(posedge clk) disable iff (!rst_n)
    d2x.val && !d2x.rdy |=> d2x.val && $stable(d2x.msg) && $stable(d2x.pc))
    else $error("d2x message changed while stalled");

endmodule

`default_nettype wire

// File: design/blimp_execute.sv
// Blimp execute stage
// ALU on the decoded operands, registered into a result message
`timescale 1ns/1ps
`default_nettype none

module blimp_execute (
  input  logic       clk,
  input  logic       rst_n,
  blimp_pipe_if.down d2x,
  blimp_pipe_if.up   x2r
);
  import blimp_pkg::*;

  logic [xlen-1:0] alu_out;
  logic            out_val;
  logic [xlen-1:0] out_pc;
  res_msg_t        out_msg;
  logic            d2x_fire;
  logic            x2r_fire;

  // --------------------
  // ALU
  // --------------------

  always_comb begin
    case (d2x.msg.alu_op)
      alu_add: alu_out = d2x.msg.op_a + d2x.msg.op_b;
      alu_sub: alu_out = d2x.msg.op_a - d2x.msg.op_b;
      alu_and: alu_out = d2x.msg.op_a & d2x.msg.op_b;
      alu_or:  alu_out = d2x.msg.op_a | d2x.msg.op_b;
      alu_xor: alu_out = d2x.msg.op_a ^ d2x.msg.op_b;
      // Signed compare, result is 0 or 1
      alu_slt: alu_out = {{(xlen-1){1'b0}},
                          $signed(d2x.msg.op_a) < $signed(d2x.msg.op_b)};
      default: alu_out = d2x.msg.op_b;
    endcase
  end

  // --------------------
  // x2r output register
  // --------------------

  // Ready when empty or draining this cycle
  assign d2x.rdy  = !out_val || x2r.rdy;
  assign d2x_fire = d2x.val && d2x.rdy;
  assign x2r_fire = out_val && x2r.rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_val <= 1'b0;
    end else if (d2x_fire) begin
      out_val <= 1'b1;
    end else if (x2r_fire) begin
      out_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (d2x_fire) begin
      out_pc  <= d2x.pc;
      out_msg <= '{waddr: d2x.msg.waddr, wdata: alu_out, wen: d2x.msg.wen};
    end
  end

  assign x2r.val = out_val;
  assign x2r.pc  = out_pc;
  assign x2r.msg = out_msg;

endmodule

`default_nettype wire

// File: design/blimp_result.sv
// Blimp result stage
// Writes back to the register file and publishes the retire trace
`timescale 1ns/1ps
`default_nettype none

module blimp_result (
  input  logic                                clk,
  input  logic                                rst_n,
  blimp_pipe_if.down                          x2r,
  output logic                                rf_wen,
  output logic [blimp_pkg::reg_addr_bits-1:0] rf_waddr,
  output logic [blimp_pkg::xlen-1:0]          rf_wdata,
  output logic                                trace_val,
  output logic [blimp_pkg::xlen-1:0]          trace_pc,
  output logic [blimp_pkg::reg_addr_bits-1:0] trace_waddr,
  output logic [blimp_pkg::xlen-1:0]          trace_wdata,
  output logic                                trace_wen
);
  import blimp_pkg::*;

  // Last stage never back-pressures
  assign x2r.rdy = 1'b1;

  // Writeback in the transfer cycle
  assign rf_wen   = x2r.val && x2r.msg.wen;
  assign rf_waddr = x2r.msg.waddr;
  assign rf_wdata = x2r.msg.wdata;

  // Trace pulse one cycle after retire
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) trace_val <= 1'b0;
    else trace_val <= x2r.val;
  end

  always_ff @(posedge clk) begin
    if (x2r.val) begin
      trace_pc    <= x2r.pc;
      trace_waddr <= x2r.msg.waddr;
      trace_wdata <= x2r.msg.wdata;
      trace_wen   <= x2r.msg.wen;
    end
  end

  // Decode must never let a write to x0 through
  assert property (@(posedge clk) disable iff (!rst_n)
    rf_wen |-> rf_waddr != reg_addr_bits'(0))
    else $error("register write to x0");

endmodule

`default_nettype wire

// File: design/blimp_core.sv
// Blimp core top level
// Four-stage in-order RV32I subset with an AXI4-Lite instruction read
// port and an instruction trace output
`timescale 1ns/1ps
`default_nettype none

module blimp_core (
  input  logic                                clk,
  input  logic                                rst_n,
  // AXI4-Lite read, core is master
  output logic [blimp_pkg::xlen-1:0]          araddr,
  output logic                                arvalid,
  input  logic                                arready,
  input  logic [blimp_pkg::xlen-1:0]          rdata,
  input  logic                                rvalid,
  output logic                                rready,
  // Retire trace, one pulse per instruction
  output logic                                trace_val,
  output logic [blimp_pkg::xlen-1:0]          trace_pc,
  output logic [blimp_pkg::reg_addr_bits-1:0] trace_waddr,
  output logic [blimp_pkg::xlen-1:0]          trace_wdata,
  output logic                                trace_wen
);
  import blimp_pkg::*;

  // --------------------
  // Stage pipes
  // --------------------

  blimp_pipe_if #(.t_msg(inst_msg_t)) f2d ();
  blimp_pipe_if #(.t_msg(dec_msg_t))  d2x ();
  blimp_pipe_if #(.t_msg(res_msg_t))  x2r ();

  // Writeback path back into decode
  logic                     rf_wen;
  logic [reg_addr_bits-1:0] rf_waddr;
  logic [xlen-1:0]          rf_wdata;

  // --------------------
  // Stages
  // --------------------

  blimp_fetch u_fetch (
    .clk     (clk),
    .rst_n   (rst_n),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rvalid  (rvalid),
    .rready  (rready),
    .f2d     (f2d)
  );

  blimp_decode u_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .f2d      (f2d),
    .d2x      (d2x),
    .rf_wen   (rf_wen),
    .rf_waddr (rf_waddr),
    .rf_wdata (rf_wdata)
  );

  blimp_execute u_execute (
    .clk   (clk),
    .rst_n (rst_n),
    .d2x   (d2x),
    .x2r   (x2r)
  );

  blimp_result u_result (
    .clk         (clk),
    .rst_n       (rst_n),
    .x2r         (x2r),
    .rf_wen      (rf_wen),
    .rf_waddr    (rf_waddr),
    .rf_wdata    (rf_wdata),
    .trace_val   (trace_val),
    .trace_pc    (trace_pc),
    .trace_waddr (trace_waddr),
    .trace_wdata (trace_wdata),
    .trace_wen   (trace_wen)
  );

endmodule

`default_nettype wire

// File: bench/blimp_tb.sv
// Blimp core testbench
// AXI4-Lite instruction memory with random stalls, and a retire trace
// checker driven from the test data file
`timescale 1ns/1ps
`default_nettype none

module blimp_tb;
  import blimp_pkg::*;

  localparam int max_entries = 64;

  logic                     clk     = 1'b0;
  logic                     rst_n   = 1'b0;
  logic                     arready = 1'b0;
  logic [xlen-1:0]          rdata   = '0;
  logic                     rvalid  = 1'b0;
  logic [xlen-1:0]          araddr;
  logic                     arvalid;
  logic                     rready;
  logic                     trace_val;
  logic [xlen-1:0]          trace_pc;
  logic [reg_addr_bits-1:0] trace_waddr;
  logic [xlen-1:0]          trace_wdata;
  logic                     trace_wen;

  // Count word, then inst / waddr / wdata / wen per entry
  logic [31:0] td [0:4*max_entries];
  int          num_entries = 0;
  int          retired     = 0;
  int          errors      = 0;
  int          cycles      = 0;
  int          cycle_limit = 0;
  integer      seed        = 61;

  // Memory model state
  logic            busy      = 1'b0;
  logic [xlen-1:0] rd_addr   = '0;
  logic [1:0]      wait_cnt  = '0;
  logic            ar_plan   = 1'b0;
  logic [xlen-1:0] plan_addr = '0;
  logic            r_plan    = 1'b0;
  logic            ar_rdy;
  logic            r_vld;
  logic [xlen-1:0] r_dat;

  blimp_core u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .arready     (arready),
    .rdata       (rdata),
    .rvalid      (rvalid),
    .rready      (rready),
    .trace_val   (trace_val),
    .trace_pc    (trace_pc),
    .trace_waddr (trace_waddr),
    .trace_wdata (trace_wdata),
    .trace_wen   (trace_wen)
  );

  // 20 ns period
  always #10 clk = ~clk;

  always @(posedge clk) cycles <= cycles + 1;

  // Program word at a byte address and nops past the end
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < num_entries) return td[1 + 4*idx];
    return nop_inst;
  endfunction

  // --------------------
  // AXI read slave
  // --------------------

  // Handshakes for the coming rising edge are worked out here
  always @(negedge clk) begin
    if (rst_n) begin
      if (r_plan) busy = 1'b0;
      if (ar_plan) begin
        busy     = 1'b1;
        rd_addr  = plan_addr;
        wait_cnt = 2'($random(seed) & 3);
      end
      // One read open at a time and taken about 3 cycles in 4
      ar_rdy = !busy && (($random(seed) & 3) != 0);
      r_vld  = 1'b0;
      r_dat  = '0;
      if (busy) begin
        if (wait_cnt == 2'd0) begin
          r_vld = 1'b1;
          r_dat = mem_word(rd_addr);
        end else begin
          wait_cnt = wait_cnt - 2'd1;
        end
      end
      arready   <= ar_rdy;
      rvalid    <= r_vld;
      rdata     <= r_dat;
      ar_plan   = arvalid && ar_rdy;
      plan_addr = araddr;
      r_plan    = r_vld && rready;
    end
  end

  // --------------------
  // Trace checker
  // --------------------

  task automatic check_trace(input int idx);
    logic [31:0] exp_pc;
    logic        exp_wen;
    exp_pc  = 32'(idx * 4);
    exp_wen = td[4 + 4*idx][0];
    if (trace_pc !== exp_pc) begin
      $display("mismatch at %0t: trace_pc got %h expected %h", $time, trace_pc, exp_pc);
      errors++;
    end
    if (trace_wen !== exp_wen) begin
      $display("mismatch at %0t: trace_wen got %b expected %b", $time, trace_wen, exp_wen);
      errors++;
    end
    // Address and data only mean something on a write
    if (exp_wen) begin
      if (trace_waddr !== td[2 + 4*idx][4:0]) begin
        $display("mismatch at %0t: trace_waddr got %0d expected %0d",
                 $time, trace_waddr, td[2 + 4*idx][4:0]);
        errors++;
      end
      if (trace_wdata !== td[3 + 4*idx]) begin
        $display("mismatch at %0t: trace_wdata got %h expected %h",
                 $time, trace_wdata, td[3 + 4*idx]);
        errors++;
      end
    end
  endtask

  always @(negedge clk) begin
    if (rst_n && trace_val) begin
      check_trace(retired);
      retired++;
    end
  end

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    $readmemh("bench/blimp_testdata.mem", td);
    num_entries = int'(td[0]);
    if (num_entries < 1 || num_entries > max_entries) begin
      $display("Test data entry count %0d is out of range", num_entries);
      errors++;
      num_entries = 0;
    end
    cycle_limit = 40 * num_entries + 200;
    repeat (8) @(negedge clk);
    rst_n <= 1'b1;
    while (retired < num_entries && cycles < cycle_limit) @(posedge clk);
    if (retired < num_entries) begin
      $display("Timeout: trace stopped after %0d of %0d instructions", retired, num_entries);
      errors++;
    end
    $display("Checked %0d of %0d traces, %0d errors", retired, num_entries, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/blimp_testdata.mem
// First word: entry count. Then one entry per line:
// instruction, expected waddr, expected wdata, expected wen (all hex)
10
00500093 01 00000005 1  // addi x1, x0, 5
ffd00113 02 fffffffd 1  // addi x2, x0, -3
123451b7 03 12345000 1  // lui x3, 0x12345
00208233 04 00000002 1  // add x4, x1, x2
401202b3 05 fffffffd 1  // sub x5, x4, x1
0012a333 06 00000001 1  // slt x6, x5, x1 (signed, -3 < 5)
0021c3b3 07 edcbaffd 1  // xor x7, x3, x2
0013f433 08 00000005 1  // and x8, x7, x1
003464b3 09 12345005 1  // or x9, x8, x3
00708013 00 00000000 0  // addi x0, x1, 7
00012083 00 00000000 0  // lw x1, 0(x2), not decoded
00100533 0a 00000005 1  // add x10, x0, x1
0020a5b3 0b 00000000 1  // slt x11, x1, x2 (5 < -3 is false)
fff58613 0c ffffffff 1  // addi x12, x11, -1
00c60633 0c fffffffe 1  // add x12, x12, x12
40c006b3 0d 00000002 1  // sub x13, x0, x12

// File: tb.f
design/blimp_pkg.sv
design/blimp_pipe_if.sv
design/blimp_fetch.sv
design/blimp_decode.sv
design/blimp_execute.sv
design/blimp_result.sv
design/blimp_core.sv
bench/blimp_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = blimp_tb
FILELIST  = tb.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir
